/* axil2apb.f */
axil2apb_pkg.sv
axil_skid_buffer.sv
axil_req_arbiter.sv
apb_transfer.sv
axil_response.sv
axil2apb.sv
axil2apb_sva.sv
tb_axil2apb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_axil2apb -f axil2apb.f
./obj_dir/Vtb_axil2apb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

/* tb_axil2apb.sv */
`default_nettype none

module tb_axil2apb;

	// Transfers across all tests, and a generous per-transfer budget
	localparam int NUM_TXN = 96;
	localparam int TXN_CYCLES = 10;
	localparam int CYCLE_LIMIT = 4 * NUM_TXN * TXN_CYCLES + 10;

	logic S_AXI_ACLK, S_AXI_ARESETN;
	logic awvalid, wvalid, arvalid, bready, rready;
	wire awready, wready, arready, bvalid, rvalid;
	logic [31:0] awaddr, araddr, wdata;
	logic [3:0] wstrb;
	logic [2:0] awprot, arprot;
	wire [1:0] bresp, rresp;
	wire [31:0] rdata, paddr, pwdata;
	wire psel, penable, pwrite;
	wire [3:0] pwstrb;
	wire [2:0] pprot;
	logic pready, pslverr;
	logic [31:0] prdata;

	logic [31:0] rng_state = 32'd43;
	logic [31:0] rnd_ready;
	logic [31:0] mem [64];
	logic [31:0] shadow [64];
	logic [35:0] exp_apb [$];
	logic [1:0] exp_b [$];
	logic [33:0] exp_r [$];
	logic [5:0] words [16];
	logic stall_en;
	int errors, checks, cycles, err_mark;

	axil2apb dut0 (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
		.S_AXI_AWADDR(awaddr), .S_AXI_AWPROT(awprot),
		.S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready),
		.S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb),
		.S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready), .S_AXI_BRESP(bresp),
		.S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
		.S_AXI_ARADDR(araddr), .S_AXI_ARPROT(arprot),
		.S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
		.S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
		.M_APB_PSEL(psel), .M_APB_PENABLE(penable), .M_APB_PREADY(pready),
		.M_APB_PADDR(paddr), .M_APB_PWRITE(pwrite), .M_APB_PWDATA(pwdata),
		.M_APB_PWSTRB(pwstrb), .M_APB_PPROT(pprot),
		.M_APB_PRDATA(prdata), .M_APB_PSLVERR(pslverr));

	// xorshift32
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic step();
		@(posedge S_AXI_ACLK);
		#5;
	endtask

	//////////////////////////////
	// Clock, cycle count, timeout
	//////////////////////////////

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #50 S_AXI_ACLK = !S_AXI_ACLK;
	end

	always @(posedge S_AXI_ACLK)
		cycles++;

	initial
	begin
		wait (cycles >= CYCLE_LIMIT);
		$display("Timeout after %0d cycles with transfers still pending", cycles);
		$display("Test failed");
		$finish;
	end

	//////////////////////////////
	// APB slave model
	//////////////////////////////

	// Commit writes on completion, then pick the next cycle's wait state
	always @(posedge S_AXI_ACLK)
	begin
		if (psel && penable && pready && pwrite && paddr[7:2] < 6'd48)
			for (int b = 0; b < 4; b++)
				if (pwstrb[b])
					mem[paddr[7:2]][8*b +: 8] = pwdata[8*b +: 8];
		#5;
		pready  = psel && (next_rand() % 3 != 0);
		pslverr = psel && paddr[7:2] >= 6'd48;
		prdata  = (psel && paddr[7:2] < 6'd48) ? mem[paddr[7:2]] : 32'h0;
	end

	// Random response stalls when enabled
	always @(posedge S_AXI_ACLK)
	begin
		#5;
		rnd_ready = next_rand();
		bready = !stall_en || rnd_ready[0];
		rready = !stall_en || rnd_ready[1];
	end

	//////////////////////////////
	// Monitors
	//////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN && psel && !penable)
		begin
			if (exp_apb.size() == 0)
			begin
				$display("APB transfer started with no request outstanding");
				errors++;
			end
			else
			begin
				compare_value("M_APB_PWRITE", {31'h0, pwrite}, {31'h0, exp_apb[0][35]});
				compare_value("M_APB_PPROT", {29'h0, pprot}, {29'h0, exp_apb[0][34:32]});
				compare_value("M_APB_PADDR", paddr, exp_apb[0][31:0]);
				void'(exp_apb.pop_front());
			end
		end
		if (S_AXI_ARESETN && bvalid && bready)
		begin
			if (exp_b.size() == 0)
			begin
				$display("B response arrived with no write outstanding");
				errors++;
			end
			else
				compare_value("S_AXI_BRESP", {30'h0, bresp}, {30'h0, exp_b.pop_front()});
		end
		if (S_AXI_ARESETN && rvalid && rready)
		begin
			if (exp_r.size() == 0)
			begin
				$display("R response arrived with no read outstanding");
				errors++;
			end
			else
			begin
				compare_value("S_AXI_RRESP", {30'h0, rresp}, {30'h0, exp_r[0][33:32]});
				// Data only meaningful on OKAY
				if (exp_r[0][33:32] == 2'b00)
					compare_value("S_AXI_RDATA", rdata, exp_r[0][31:0]);
				void'(exp_r.pop_front());
			end
		end
	end

	//////////////////////////////
	// AXI-lite driver
	//////////////////////////////

	// Writes merge into the shadow; error region left untouched
	task automatic send_req(input logic do_wr, input logic do_rd,
		input logic [31:0] wa, input logic [31:0] wd, input logic [3:0] ws,
		input logic [2:0] wp, input logic [31:0] ra, input logic [2:0] rp);
		logic aw_done, w_done, ar_done;
		aw_done = !do_wr;
		w_done  = !do_wr;
		ar_done = !do_rd;
		if (do_wr)
		begin
			exp_apb.push_back({1'b1, wp, wa & ~32'h3});
			if (wa[7:2] < 6'd48)
			begin
				for (int b = 0; b < 4; b++)
					if (ws[b])
						shadow[wa[7:2]][8*b +: 8] = wd[8*b +: 8];
				exp_b.push_back(2'b00);
			end
			else
				exp_b.push_back(2'b10);
			{awvalid, awaddr, awprot, wvalid, wdata, wstrb} = {1'b1, wa, wp, 1'b1, wd, ws};
		end
		if (do_rd)
		begin
			exp_apb.push_back({1'b0, rp, ra & ~32'h3});
			if (ra[7:2] < 6'd48)
				exp_r.push_back({2'b00, shadow[ra[7:2]]});
			else
				exp_r.push_back({2'b10, 32'h0});
			{arvalid, araddr, arprot} = {1'b1, ra, rp};
		end
		while (!(aw_done && w_done && ar_done))
		begin
			@(posedge S_AXI_ACLK);
			aw_done = aw_done || (awvalid && awready);
			w_done  = w_done || (wvalid && wready);
			ar_done = ar_done || (arvalid && arready);
			#5;
			awvalid = awvalid && !aw_done;
			wvalid  = wvalid && !w_done;
			arvalid = arvalid && !ar_done;
		end
	endtask

	task automatic drain();
		while (exp_apb.size() != 0 || exp_b.size() != 0 || exp_r.size() != 0)
			step();
	endtask

	task automatic report_test(input string name);
		$display("%-22s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		{awvalid, wvalid, arvalid, bready, rready, pready, pslverr} = '0;
		{awaddr, araddr, wdata, prdata, wstrb, awprot, arprot} = '0;
		stall_en = 1'b0;
		// Same whole-address fill in model and shadow
		for (int i = 0; i < 64; i++)
		begin
			mem[i] = 32'h5A5A0000 ^ (i * 32'h9E3779B1);
			shadow[i] = mem[i];
		end
		S_AXI_ARESETN = 1'b0;
		repeat (10) @(posedge S_AXI_ACLK);
		#5;
		S_AXI_ARESETN = 1'b1;
		step();

		// Write and read presented together, back to back
		// First pair meets an idle bus
		for (int i = 0; i < 8; i++)
			send_req(1, 1, {24'h0, 6'(i), 2'(next_rand())}, next_rand(), 4'hF,
				3'(next_rand()), {24'h0, 6'(24 + i), 2'b00}, 3'(next_rand()));
		drain();
		report_test("alternation");

		for (int i = 0; i < 16; i++)
		begin
			words[i] = 6'(next_rand() % 48);
			send_req(1, 0, {24'h0, words[i], 2'(next_rand())}, next_rand(),
				4'(next_rand()), 3'(next_rand()), '0, '0);
		end
		drain();
		for (int i = 0; i < 16; i++)
			send_req(0, 1, '0, '0, '0, '0, {24'h0, words[i], 2'(next_rand())},
				3'(next_rand()));
		drain();
		report_test("write readback");

		for (int i = 0; i < 8; i++)
			send_req(1, 0, {24'h0, 6'(48 + next_rand() % 16), 2'b00}, next_rand(),
				4'hF, 3'(next_rand()), '0, '0);
		drain();
		for (int i = 0; i < 8; i++)
			send_req(0, 1, '0, '0, '0, '0, {24'h0, 6'(48 + next_rand() % 16), 2'b00},
				3'(next_rand()));
		drain();
		report_test("error region");

		stall_en = 1'b1;
		for (int i = 0; i < 16; i++)
			send_req(1, 0, {24'h0, 6'(next_rand() % 48), 2'b00}, next_rand(),
				4'(next_rand()), 3'(next_rand()), '0, '0);
		drain();
		for (int i = 0; i < 16; i++)
			send_req(0, 1, '0, '0, '0, '0, {24'h0, 6'(next_rand() % 48), 2'b00},
				3'(next_rand()));
		drain();
		stall_en = 1'b0;
		report_test("back-pressure");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* axil2apb_sva.sv */
`default_nettype none

module axil2apb_sva (
	input wire        S_AXI_ACLK,
	input wire        S_AXI_ARESETN,
	input wire        M_APB_PSEL,
	input wire        M_APB_PENABLE,
	input wire        M_APB_PREADY,
	input wire [31:0] M_APB_PADDR,
	input wire        M_APB_PWRITE,
	input wire [31:0] M_APB_PWDATA,
	input wire [2:0]  M_APB_PPROT,
	input wire        S_AXI_BVALID,
	input wire        S_AXI_BREADY,
	input wire [1:0]  S_AXI_BRESP,
	input wire        S_AXI_RVALID,
	input wire        S_AXI_RREADY,
	input wire [31:0] S_AXI_RDATA,
	input wire [1:0]  S_AXI_RRESP
);

	//////////////////////////////
	// APB phases
	//////////////////////////////

	penable_needs_psel: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		M_APB_PENABLE |-> M_APB_PSEL)
		else $error("PENABLE high without PSEL");

	// Setup lasts exactly one cycle
	setup_then_access: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$rose(M_APB_PSEL) |=> M_APB_PENABLE)
		else $error("PENABLE did not follow PSEL by one cycle");

	// Request fields frozen until the access completes
	fields_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		M_APB_PSEL && !(M_APB_PENABLE && M_APB_PREADY) |=>
		$stable(M_APB_PADDR) && $stable(M_APB_PWRITE) && $stable(M_APB_PWDATA)
		&& $stable(M_APB_PPROT))
		else $error("APB request fields changed during a transfer");

	//////////////////////////////
	// Response hold under stall
	//////////////////////////////

	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID && $stable(S_AXI_BRESP))
		else $error("B channel dropped or changed while stalled");

	r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=>
		S_AXI_RVALID && $stable(S_AXI_RDATA) && $stable(S_AXI_RRESP))
		else $error("R channel dropped or changed while stalled");

endmodule

bind axil2apb axil2apb_sva sva0 (.*);

`default_nettype wire

/* axil2apb.sv */
`default_nettype none

module axil2apb (
	input  wire                                S_AXI_ACLK,
	input  wire                                S_AXI_ARESETN,
	// AXI-lite write address
	input  wire                                S_AXI_AWVALID,
	output wire                                S_AXI_AWREADY,
	input  wire [axil2apb_pkg::ADDR_W-1:0]     S_AXI_AWADDR,
	input  wire [axil2apb_pkg::PROT_W-1:0]     S_AXI_AWPROT,
	// AXI-lite write data
	input  wire                                S_AXI_WVALID,
	output wire                                S_AXI_WREADY,
	input  wire [axil2apb_pkg::DATA_W-1:0]     S_AXI_WDATA,
	input  wire [axil2apb_pkg::STRB_W-1:0]     S_AXI_WSTRB,
	// AXI-lite write response
	output wire                                S_AXI_BVALID,
	input  wire                                S_AXI_BREADY,
	output wire [axil2apb_pkg::RESP_W-1:0]     S_AXI_BRESP,
	// AXI-lite read address
	input  wire                                S_AXI_ARVALID,
	output wire                                S_AXI_ARREADY,
	input  wire [axil2apb_pkg::ADDR_W-1:0]     S_AXI_ARADDR,
	input  wire [axil2apb_pkg::PROT_W-1:0]     S_AXI_ARPROT,
	// AXI-lite read data
	output wire                                S_AXI_RVALID,
	input  wire                                S_AXI_RREADY,
	output wire [axil2apb_pkg::DATA_W-1:0]     S_AXI_RDATA,
	output wire [axil2apb_pkg::RESP_W-1:0]     S_AXI_RRESP,
	// APB master
	output wire                                M_APB_PSEL,
	output wire                                M_APB_PENABLE,
	input  wire                                M_APB_PREADY,
	output wire [axil2apb_pkg::ADDR_W-1:0]     M_APB_PADDR,
	output wire                                M_APB_PWRITE,
	output wire [axil2apb_pkg::DATA_W-1:0]     M_APB_PWDATA,
	output wire [axil2apb_pkg::STRB_W-1:0]     M_APB_PWSTRB,
	output wire [axil2apb_pkg::PROT_W-1:0]     M_APB_PPROT,
	input  wire [axil2apb_pkg::DATA_W-1:0]     M_APB_PRDATA,
	input  wire                                M_APB_PSLVERR
);

	// Skid buffer outputs
	wire                               aw_valid, w_valid, ar_valid;
	wire [axil2apb_pkg::WADDR_W-1:0]   aw_addr, ar_addr;
	wire [axil2apb_pkg::PROT_W-1:0]    aw_prot, ar_prot;
	wire [axil2apb_pkg::DATA_W-1:0]    w_data;
	wire [axil2apb_pkg::STRB_W-1:0]    w_strb;

	// Arbiter and engine handshakes
	wire                               wr_issue, rd_issue, apb_idle;
	wire                               wr_done, rd_done, done_err;
	wire [axil2apb_pkg::DATA_W-1:0]    done_data;

	//////////////////////////////
	// Request skid buffers
	//////////////////////////////

	// Byte offset bits of the AXI addresses are dropped here
	axil_skid_buffer #(.WIDTH(axil2apb_pkg::AREQ_W)) aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_AXI_AWVALID), .o_ready(S_AXI_AWREADY),
		.i_data({S_AXI_AWADDR[axil2apb_pkg::ADDR_W-1:axil2apb_pkg::ADDR_LSB], S_AXI_AWPROT}),
		.o_valid(aw_valid), .i_ready(wr_issue), .o_data({aw_addr, aw_prot}));

	axil_skid_buffer #(.WIDTH(axil2apb_pkg::WREQ_W)) w_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_AXI_WVALID), .o_ready(S_AXI_WREADY),
		.i_data({S_AXI_WDATA, S_AXI_WSTRB}),
		.o_valid(w_valid), .i_ready(wr_issue), .o_data({w_data, w_strb}));

	axil_skid_buffer #(.WIDTH(axil2apb_pkg::AREQ_W)) ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_AXI_ARVALID), .o_ready(S_AXI_ARREADY),
		.i_data({S_AXI_ARADDR[axil2apb_pkg::ADDR_W-1:axil2apb_pkg::ADDR_LSB], S_AXI_ARPROT}),
		.o_valid(ar_valid), .i_ready(rd_issue), .o_data({ar_addr, ar_prot}));

	//////////////////////////////
	// Arbitration and APB
	//////////////////////////////

	// Both write buffers pop on the same issue
	axil_req_arbiter arb (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_aw_valid(aw_valid), .i_w_valid(w_valid), .i_ar_valid(ar_valid),
		.i_apb_idle(apb_idle),
		.i_bvalid(S_AXI_BVALID), .i_bready(S_AXI_BREADY),
		.i_rvalid(S_AXI_RVALID), .i_rready(S_AXI_RREADY),
		.o_wr_issue(wr_issue), .o_rd_issue(rd_issue));

	apb_transfer apb (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr_issue(wr_issue), .i_rd_issue(rd_issue),
		.i_aw_addr(aw_addr), .i_ar_addr(ar_addr),
		.i_aw_prot(aw_prot), .i_ar_prot(ar_prot),
		.i_wdata(w_data), .i_wstrb(w_strb),
		.o_psel(M_APB_PSEL), .o_penable(M_APB_PENABLE), .o_pwrite(M_APB_PWRITE),
		.o_paddr(M_APB_PADDR), .o_pwdata(M_APB_PWDATA),
		.o_pwstrb(M_APB_PWSTRB), .o_pprot(M_APB_PPROT),
		.i_pready(M_APB_PREADY), .i_prdata(M_APB_PRDATA), .i_pslverr(M_APB_PSLVERR),
		.o_apb_idle(apb_idle),
		.o_wr_done(wr_done), .o_rd_done(rd_done),
		.o_done_err(done_err), .o_done_data(done_data));

	//////////////////////////////
	// Response channels
	//////////////////////////////

	axil_response resp (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_wr_done(wr_done), .i_rd_done(rd_done),
		.i_done_err(done_err), .i_done_data(done_data),
		.o_bvalid(S_AXI_BVALID), .i_bready(S_AXI_BREADY), .o_bresp(S_AXI_BRESP),
		.o_rvalid(S_AXI_RVALID), .i_rready(S_AXI_RREADY),
		.o_rdata(S_AXI_RDATA), .o_rresp(S_AXI_RRESP));

endmodule

`default_nettype wire

/* axil_response.sv */
`default_nettype none

module axil_response (
	input  logic                               S_AXI_ACLK,
	input  logic                               S_AXI_ARESETN,
	// Completion from the APB engine
	input  logic                               i_wr_done,
	input  logic                               i_rd_done,
	input  logic                               i_done_err,
	input  logic [axil2apb_pkg::DATA_W-1:0]    i_done_data,
	// AXI-lite B channel
	output logic                               o_bvalid,
	input  logic                               i_bready,
	output logic [axil2apb_pkg::RESP_W-1:0]    o_bresp,
	// AXI-lite R channel
	output logic                               o_rvalid,
	input  logic                               i_rready,
	output logic [axil2apb_pkg::DATA_W-1:0]    o_rdata,
	output logic [axil2apb_pkg::RESP_W-1:0]    o_rresp
);

	// AXI code for the finishing transfer
	logic [axil2apb_pkg::RESP_W-1:0] done_resp;

	// Register free this cycle
	logic b_load;
	logic r_load;

	assign done_resp = i_done_err ? axil2apb_pkg::RESP_SLVERR : axil2apb_pkg::RESP_OKAY;

	// Empty or being accepted
	assign b_load = !o_bvalid || i_bready;
	assign r_load = !o_rvalid || i_rready;

	//////////////////////////////
	// Write response
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (b_load)
			o_bvalid <= i_wr_done;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (b_load && i_wr_done)
			o_bresp <= done_resp;
	end

	//////////////////////////////
	// Read response
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (r_load)
			o_rvalid <= i_rd_done;
	end

	// Data and code stay put while the master stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (r_load && i_rd_done)
		begin
			o_rdata <= i_done_data;
			o_rresp <= done_resp;
		end
	end

endmodule

`default_nettype wire

/* apb_transfer.sv */
`default_nettype none

module apb_transfer (
	input  logic                               S_AXI_ACLK,
	input  logic                               S_AXI_ARESETN,
	// Issue strobes from the arbiter
	input  logic                               i_wr_issue,
	input  logic                               i_rd_issue,
	// Request payloads from the skid buffers
	input  logic [axil2apb_pkg::WADDR_W-1:0]   i_aw_addr,
	input  logic [axil2apb_pkg::WADDR_W-1:0]   i_ar_addr,
	input  logic [axil2apb_pkg::PROT_W-1:0]    i_aw_prot,
	input  logic [axil2apb_pkg::PROT_W-1:0]    i_ar_prot,
	input  logic [axil2apb_pkg::DATA_W-1:0]    i_wdata,
	input  logic [axil2apb_pkg::STRB_W-1:0]    i_wstrb,
	// APB master
	output logic                               o_psel,
	output logic                               o_penable,
	output logic                               o_pwrite,
	output logic [axil2apb_pkg::ADDR_W-1:0]    o_paddr,
	output logic [axil2apb_pkg::DATA_W-1:0]    o_pwdata,
	output logic [axil2apb_pkg::STRB_W-1:0]    o_pwstrb,
	output logic [axil2apb_pkg::PROT_W-1:0]    o_pprot,
	input  logic                               i_pready,
	input  logic [axil2apb_pkg::DATA_W-1:0]    i_prdata,
	input  logic                               i_pslverr,
	// Status back to the arbiter
	output logic                               o_apb_idle,
	// Completion toward the response registers
	output logic                               o_wr_done,
	output logic                               o_rd_done,
	output logic                               o_done_err,
	output logic [axil2apb_pkg::DATA_W-1:0]    o_done_data
);

	// Access phase ending this cycle
	logic access_done;

	//////////////////////////////
	// Phase sequencing
	//////////////////////////////

	// Idle, then setup with PSEL alone, then access with PENABLE
	// Access repeats until PREADY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_psel    <= 1'b0;
			o_penable <= 1'b0;
		end
		else if (!o_psel)
		begin
			o_psel    <= i_wr_issue || i_rd_issue;
			o_penable <= 1'b0;
		end
		else if (!o_penable)
			o_penable <= 1'b1;
		else if (i_pready)
		begin
			o_psel    <= 1'b0;
			o_penable <= 1'b0;
		end
	end

	// Request fields captured at issue
	// Held steady through setup and access
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr_issue)
		begin
			o_paddr  <= {i_aw_addr, {axil2apb_pkg::ADDR_LSB{1'b0}}};
			o_pwrite <= 1'b1;
			o_pprot  <= i_aw_prot;
			o_pwdata <= i_wdata;
			o_pwstrb <= i_wstrb;
		end
		else if (i_rd_issue)
		begin
			o_paddr  <= {i_ar_addr, {axil2apb_pkg::ADDR_LSB{1'b0}}};
			o_pwrite <= 1'b0;
			o_pprot  <= i_ar_prot;
			// No byte lanes written on a read
			o_pwstrb <= '0;
		end
	end

	//////////////////////////////
	// Status and completion
	//////////////////////////////

	// Free for a new request once PSEL has dropped
	assign o_apb_idle = !o_psel;

	assign access_done = o_psel && o_penable && i_pready;

	// Split by direction of the finishing transfer
	assign o_wr_done   = access_done && o_pwrite;
	assign o_rd_done   = access_done && !o_pwrite;
	// Slave response passes straight through
	assign o_done_err  = i_pslverr;
	assign o_done_data = i_prdata;

endmodule

`default_nettype wire

/* axil_req_arbiter.sv */
`default_nettype none

module axil_req_arbiter (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// Pending requests from the skid buffers
	input  logic i_aw_valid,
	input  logic i_w_valid,
	input  logic i_ar_valid,
	// APB engine free to start
	input  logic i_apb_idle,
	// Response channel state
	input  logic i_bvalid,
	input  logic i_bready,
	input  logic i_rvalid,
	input  logic i_rready,
	// Issue strobes, never both high
	output logic o_wr_issue,
	output logic o_rd_issue
);

	// High when the next tie goes to the write side
	logic r_wr_grant;

	// Response register occupied and not draining
	logic b_stall;
	logic r_stall;

	// Side could start a transfer this cycle
	logic wr_ok;
	logic rd_ok;

	//////////////////////////////
	// Eligibility
	//////////////////////////////

	assign b_stall = i_bvalid && !i_bready;
	assign r_stall = i_rvalid && !i_rready;

	// Write needs address and data together
	assign wr_ok = i_aw_valid && i_w_valid && i_apb_idle && !b_stall;
	assign rd_ok = i_ar_valid && i_apb_idle && !r_stall;

	//////////////////////////////
	// Grant
	//////////////////////////////

	// Lone requester wins outright
	// Ties resolved by the grant register
	assign o_wr_issue = wr_ok && (r_wr_grant || !rd_ok);
	assign o_rd_issue = rd_ok && (!r_wr_grant || !wr_ok);

	// Flip toward the other side after every issue
	// Writes first out of reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_wr_grant <= 1'b1;
		else if (o_wr_issue)
			r_wr_grant <= 1'b0;
		else if (o_rd_issue)
			r_wr_grant <= 1'b1;
	end

endmodule

`default_nettype wire

/* axil_skid_buffer.sv */
`default_nettype none

module axil_skid_buffer #(
	// Payload width in bits
	parameter int WIDTH = 8
) (
	input  logic             S_AXI_ACLK,
	input  logic             S_AXI_ARESETN,
	// Upstream side
	input  logic             i_valid,
	output logic             o_ready,
	input  logic [WIDTH-1:0] i_data,
	// Downstream side
	output logic             o_valid,
	input  logic             i_ready,
	output logic [WIDTH-1:0] o_data
);

	// One holding slot
	logic             r_full;
	logic [WIDTH-1:0] r_data;

	//////////////////////////////
	// Outputs
	//////////////////////////////

	// Accept new beats only while the slot is free
	assign o_ready = !r_full;

	// Held item goes first
	// Empty buffer is a straight wire
	assign o_valid = i_valid || r_full;
	assign o_data  = r_full ? r_data : i_data;

	//////////////////////////////
	// Holding slot
	//////////////////////////////

	// Fill when an accepted beat meets a stalled output
	// Drain once downstream takes the held item
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_full <= 1'b0;
		else if (i_valid && !r_full && !i_ready)
			r_full <= 1'b1;
		else if (i_ready)
			r_full <= 1'b0;
	end

	// Payload follows the input while the slot is free
	// Frozen while full
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!r_full)
			r_data <= i_data;
	end

endmodule

`default_nettype wire

/* axil2apb_pkg.sv */
`default_nettype none

package axil2apb_pkg;

	//////////////////////////////
	// Bus widths
	//////////////////////////////

	// Address width on both buses
	localparam int ADDR_W = 32;
	// Data word width, shared by AXI-lite and APB
	localparam int DATA_W = 32;
	// One strobe bit per data byte
	localparam int STRB_W = DATA_W / 8;
	// Byte offset bits, returned as zero on PADDR
	localparam int ADDR_LSB = $clog2(STRB_W);
	// AxPROT and PPROT
	localparam int PROT_W = 3;
	// Word address carried through the request path
	localparam int WADDR_W = ADDR_W - ADDR_LSB;

	// Skid buffer payloads
	// Word address above prot, for AW and AR
	localparam int AREQ_W = WADDR_W + PROT_W;
	// Data above strobe, for W
	localparam int WREQ_W = DATA_W + STRB_W;

	//////////////////////////////
	// Response codes
	//////////////////////////////

	localparam int RESP_W = 2;
	// Normal completion
	localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;
	// APB slave raised PSLVERR
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
